// ==== rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data path and address width
`define RV_XLEN 64

// Register index width, 32 registers
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

`endif

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported RV64I subset
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // Bit 2 is the signed flag, bits 1:0 the width
    typedef enum logic [2:0] {
        LOAD_BU = 3'b000,
        LOAD_HU = 3'b001,
        LOAD_WU = 3'b010,
        LOAD_B  = 3'b100,
        LOAD_H  = 3'b101,
        LOAD_W  = 3'b110,
        LOAD_D  = 3'b111
    } load_kind_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_IMM
    } wb_src_t;

    typedef struct packed {
        logic       alua_src;   // 1 selects PC
        logic       alub_src;   // 1 selects rs2
        logic       aluy_src;   // 1 sign extends the low word
        alu_op_t    alu_op;
        logic       alupc_src;  // 1 selects rs1 as target base
        logic       pc_src;     // 1 takes the target
        logic       pc_enable;
        load_kind_t load_kind;
        wb_src_t    wb_src;
        logic       write_register_enable;
        logic       mem_write;
    } ctrl_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry_out;
        logic overflow;
    } alu_flags_t;

endpackage

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module register_file (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  write_enable,
    input  logic [`RV_REG_AW-1:0] read_address1,
    input  logic [`RV_REG_AW-1:0] read_address2,
    input  logic [`RV_REG_AW-1:0] write_address,
    input  logic [`RV_XLEN-1:0]   write_data,
    output logic [`RV_XLEN-1:0]   read_data1,
    output logic [`RV_XLEN-1:0]   read_data2
);

    localparam int REG_COUNT = 1 << `RV_REG_AW;

    logic [`RV_XLEN-1:0] regs [REG_COUNT];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_address != '0)) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 reads as zero regardless of array contents
    assign read_data1 = (read_address1 == '0) ? '0 : regs[read_address1];
    assign read_data2 = (read_address2 == '0) ? '0 : regs[read_address2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_t     op,
    output logic [`RV_XLEN-1:0] y,
    output rv_pkg::alu_flags_t  flags
);

    localparam int XLEN = `RV_XLEN;

    logic            sub_mode;
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum;
    logic            carry;
    logic            overflow;
    logic [5:0]      shamt;

    // Shared adder subtracts for sub and both compares
    assign sub_mode = (op == rv_pkg::ALU_SUB) || (op == rv_pkg::ALU_SLT)
                      || (op == rv_pkg::ALU_SLTU);
    assign b_eff    = sub_mode ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub_mode};
    assign carry    = sum[XLEN];
    assign overflow = (a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
    assign shamt    = b[5:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:  y = sum[XLEN-1:0];
            rv_pkg::ALU_SUB:  y = sum[XLEN-1:0];
            rv_pkg::ALU_AND:  y = a & b;
            rv_pkg::ALU_OR:   y = a | b;
            rv_pkg::ALU_XOR:  y = a ^ b;
            // Less than from the subtract flags
            rv_pkg::ALU_SLT:  y = {{(XLEN-1){1'b0}}, sum[XLEN-1] ^ overflow};
            rv_pkg::ALU_SLTU: y = {{(XLEN-1){1'b0}}, ~carry};
            rv_pkg::ALU_SLL:  y = a << shamt;
            rv_pkg::ALU_SRL:  y = a >> shamt;
            rv_pkg::ALU_SRA:  y = $signed(a) >>> shamt;
            default:          y = sum[XLEN-1:0];
        endcase
    end

    assign flags.zero      = (y == '0);
    assign flags.negative  = y[XLEN-1];
    assign flags.carry_out = carry;
    assign flags.overflow  = overflow;

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module imm_gen (
    input  logic [31:0]         instruction,
    output logic [`RV_XLEN-1:0] immediate
);

    logic [6:0] opcode;
    logic       sign;

    assign opcode = instruction[6:0];
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            rv_pkg::OPC_STORE:
                immediate = {{52{sign}}, instruction[31:25], instruction[11:7]};
            rv_pkg::OPC_BRANCH:
                immediate = {{51{sign}}, sign, instruction[7], instruction[30:25],
                             instruction[11:8], 1'b0};
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:
                immediate = {{32{sign}}, instruction[31:12], 12'b0};
            rv_pkg::OPC_JAL:
                immediate = {{43{sign}}, sign, instruction[19:12], instruction[20],
                             instruction[30:21], 1'b0};
            // Loads, OP-IMM, JALR and the rest use the I format
            default:
                immediate = {{52{sign}}, instruction[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// ==== dataflow.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module dataflow (
    input  logic                clock,
    input  logic                rst_n,
    input  logic [31:0]         instruction,
    output logic [`RV_XLEN-1:0] instruction_address,
    input  logic [`RV_XLEN-1:0] read_data,
    output logic [`RV_XLEN-1:0] write_data,
    output logic [`RV_XLEN-1:0] data_address,
    input  rv_pkg::ctrl_t       ctrl,
    output logic [6:0]          opcode,
    output logic [2:0]          funct3,
    output logic                funct7,
    output rv_pkg::alu_flags_t  flags
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc_next;
    logic [`RV_XLEN-1:0] pc_plus_4;
    logic [`RV_XLEN-1:0] target_base;
    logic [`RV_XLEN-1:0] target_sum;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] immediate;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] load_ext;
    logic [`RV_XLEN-1:0] wb_data;

    register_file u_regs (
        .clock         (clock),
        .rst_n         (rst_n),
        .write_enable  (ctrl.write_register_enable),
        .read_address1 (instruction[19:15]),
        .read_address2 (instruction[24:20]),
        .write_address (instruction[11:7]),
        .write_data    (wb_data),
        .read_data1    (rs1_data),
        .read_data2    (rs2_data)
    );

    imm_gen u_imm (
        .instruction (instruction),
        .immediate   (immediate)
    );

    assign alu_a = ctrl.alua_src ? pc : rs1_data;
    assign alu_b = ctrl.alub_src ? rs2_data : immediate;

    alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (ctrl.alu_op),
        .y     (alu_y),
        .flags (flags)
    );

    // W operations keep only the low word, sign extended
    assign alu_result = ctrl.aluy_src ? {{32{alu_y[31]}}, alu_y[31:0]} : alu_y;

    // Branch and JAL are PC relative, JALR is rs1 relative with bit 0 cleared
    assign pc_plus_4   = pc + `RV_XLEN'd4;
    assign target_base = ctrl.alupc_src ? rs1_data : pc;
    assign target_sum  = target_base + immediate;
    assign pc_target   = {target_sum[`RV_XLEN-1:1], target_sum[0] & ~ctrl.alupc_src};
    assign pc_next     = ctrl.pc_src ? pc_target : pc_plus_4;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else if (ctrl.pc_enable) begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (ctrl.load_kind)
            rv_pkg::LOAD_B:  load_ext = {{56{read_data[7]}}, read_data[7:0]};
            rv_pkg::LOAD_H:  load_ext = {{48{read_data[15]}}, read_data[15:0]};
            rv_pkg::LOAD_W:  load_ext = {{32{read_data[31]}}, read_data[31:0]};
            rv_pkg::LOAD_BU: load_ext = {56'b0, read_data[7:0]};
            rv_pkg::LOAD_HU: load_ext = {48'b0, read_data[15:0]};
            rv_pkg::LOAD_WU: load_ext = {32'b0, read_data[31:0]};
            default:         load_ext = read_data;
        endcase
    end

    always_comb begin
        case (ctrl.wb_src)
            rv_pkg::WB_LOAD: wb_data = load_ext;
            rv_pkg::WB_PC4:  wb_data = pc_plus_4;
            rv_pkg::WB_IMM:  wb_data = immediate;
            default:         wb_data = alu_result;
        endcase
    end

    assign instruction_address = pc;
    assign data_address        = alu_y;
    assign write_data          = rs2_data;

    // Fields for the control unit
    // Bit 30 alone tells sub from add and sra from srl
    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[30];

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic [6:0]         opcode,
    input  logic [2:0]         funct3,
    input  logic               funct7,
    input  rv_pkg::alu_flags_t flags,
    output rv_pkg::ctrl_t      ctrl
);

    logic branch_taken;

    // funct3 to ALU operation for OP and OP-IMM
    function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    // Flags come from rs1 - rs2
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = flags.zero;
            3'b001:  branch_taken = ~flags.zero;
            3'b100:  branch_taken = flags.negative ^ flags.overflow;
            3'b101:  branch_taken = ~(flags.negative ^ flags.overflow);
            3'b110:  branch_taken = ~flags.carry_out;
            3'b111:  branch_taken = flags.carry_out;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.load_kind = rv_pkg::LOAD_D;
        ctrl.wb_src    = rv_pkg::WB_ALU;
        ctrl.pc_enable = 1'b1;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                ctrl.wb_src                = rv_pkg::WB_IMM;
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.alua_src              = 1'b1;
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.pc_src                = 1'b1;
                ctrl.wb_src                = rv_pkg::WB_PC4;
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.pc_src                = 1'b1;
                ctrl.alupc_src             = 1'b1;
                ctrl.wb_src                = rv_pkg::WB_PC4;
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.alub_src = 1'b1;
                ctrl.alu_op   = rv_pkg::ALU_SUB;
                ctrl.pc_src   = branch_taken;
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 != 3'b111) begin
                    ctrl.load_kind = rv_pkg::load_kind_t'({~funct3[2], funct3[1:0]});
                    ctrl.wb_src    = rv_pkg::WB_LOAD;
                    ctrl.write_register_enable = 1'b1;
                end else begin
                    ctrl.pc_enable = 1'b0;
                end
            end
            // SD is the only store
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b011) ctrl.mem_write = 1'b1;
                else ctrl.pc_enable = 1'b0;
            end
            rv_pkg::OPC_OP: begin
                ctrl.alub_src              = 1'b1;
                ctrl.alu_op                = arith_op(funct3, funct7);
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_OP_IMM: begin
                // Bit 30 is part of the immediate except for the right shifts
                ctrl.alu_op                = arith_op(funct3, funct7 && (funct3 == 3'b101));
                ctrl.write_register_enable = 1'b1;
            end
            rv_pkg::OPC_OP_32: begin
                if (funct3 == 3'b000) begin
                    ctrl.alub_src              = 1'b1;
                    ctrl.aluy_src              = 1'b1;
                    ctrl.alu_op                = funct7 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    ctrl.write_register_enable = 1'b1;
                end else begin
                    ctrl.pc_enable = 1'b0;
                end
            end
            rv_pkg::OPC_OP_IMM_32: begin
                if (funct3 == 3'b000) begin
                    ctrl.aluy_src              = 1'b1;
                    ctrl.write_register_enable = 1'b1;
                end else begin
                    ctrl.pc_enable = 1'b0;
                end
            end
            // ECALL halts on the current instruction
            rv_pkg::OPC_SYSTEM: ctrl.pc_enable = 1'b0;
            default:            ctrl.pc_enable = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== core_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module core_top (
    input  logic                clock,
    input  logic                rst_n,
    input  logic [31:0]         instruction,
    output logic [`RV_XLEN-1:0] instruction_address,
    output logic [`RV_XLEN-1:0] data_address,
    output logic [`RV_XLEN-1:0] write_data,
    output logic                mem_write,
    input  logic [`RV_XLEN-1:0] read_data
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7;
    rv_pkg::alu_flags_t flags;
    rv_pkg::ctrl_t      ctrl;

    control_unit u_control (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .flags  (flags),
        .ctrl   (ctrl)
    );

    dataflow u_dataflow (
        .clock               (clock),
        .rst_n               (rst_n),
        .instruction         (instruction),
        .instruction_address (instruction_address),
        .read_data           (read_data),
        .write_data          (write_data),
        .data_address        (data_address),
        .ctrl                (ctrl),
        .opcode              (opcode),
        .funct3              (funct3),
        .funct7              (funct7),
        .flags               (flags)
    );

    assign mem_write = ctrl.mem_write;

endmodule

`default_nettype wire

// ==== tb_core.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module tb_core;

    localparam logic [6:0] OPC_LOAD     = 7'h03;
    localparam logic [6:0] OPC_OP_IMM   = 7'h13;
    localparam logic [6:0] OPC_AUIPC    = 7'h17;
    localparam logic [6:0] OPC_OP_IMM_W = 7'h1b;
    localparam logic [6:0] OPC_STORE    = 7'h23;
    localparam logic [6:0] OPC_OP       = 7'h33;
    localparam logic [6:0] OPC_LUI      = 7'h37;
    localparam logic [6:0] OPC_OP_W     = 7'h3b;
    localparam logic [6:0] OPC_BRANCH   = 7'h63;
    localparam logic [6:0] OPC_JALR     = 7'h67;
    localparam logic [6:0] OPC_JAL      = 7'h6f;
    localparam logic [6:0] OPC_SYSTEM   = 7'h73;

    localparam logic [4:0] ZERO       = 5'd0;
    localparam logic [4:0] X1         = 5'd1;
    localparam logic [4:0] X2         = 5'd2;
    localparam logic [4:0] X3         = 5'd3;
    localparam logic [4:0] MARK       = 5'd9;
    localparam logic [4:0] LINK       = 5'd10;
    localparam logic [4:0] FLAG       = 5'd11;
    localparam logic [4:0] PC_COPY    = 5'd12;
    localparam logic [4:0] LINK_R     = 5'd13;
    localparam logic [4:0] LOADED     = 5'd14;
    localparam logic [4:0] LOAD_BASE  = 5'd29;
    localparam logic [4:0] STORE_BASE = 5'd30;

    // High bit set in every load width
    localparam logic [63:0] LOAD_WORD = 64'h8123_4567_89ab_cdef;

    logic                clock = 1'b0;
    logic                rst_n;
    logic [31:0]         instruction;
    logic [`RV_XLEN-1:0] instruction_address;
    logic [`RV_XLEN-1:0] data_address;
    logic [`RV_XLEN-1:0] write_data;
    logic [`RV_XLEN-1:0] read_data;
    logic                mem_write;

    logic [31:0]         imem [512];
    logic [`RV_XLEN-1:0] dmem [512];
    logic [`RV_XLEN-1:0] ref_regs [32];
    logic [`RV_XLEN-1:0] ref_mem [512];
    logic [`RV_XLEN-1:0] exp_addr [$];
    logic [`RV_XLEN-1:0] exp_data [$];
    logic [`RV_XLEN-1:0] halt_pc;

    int          prog_len = 0;
    int          budget_cycles = 0;
    int          store_count = 0;
    int          addr_errors = 0;
    int          data_errors = 0;
    int          pc_errors = 0;
    int          other_errors = 0;
    logic [11:0] st_off;

    always #5 clock = ~clock;

    core_top u_dut (
        .clock               (clock),
        .rst_n               (rst_n),
        .instruction         (instruction),
        .instruction_address (instruction_address),
        .data_address        (data_address),
        .write_data          (write_data),
        .mem_write           (mem_write),
        .read_data           (read_data)
    );

    // Both memories answer within the cycle
    assign instruction = imem[instruction_address[10:2]];
    assign read_data   = dmem[data_address[11:3]];

    always @(posedge clock) begin
        if (rst_n && mem_write) begin
            dmem[data_address[11:3]] = write_data;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
    endfunction

    task automatic emit(input logic [31:0] ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    // Each stored result gets its own doubleword
    task automatic store_reg(input logic [4:0] rs);
        emit(s_type(st_off, rs, STORE_BASE, 3'b011, OPC_STORE));
        st_off = st_off + 12'd8;
    endtask

    task automatic build_program();
        logic [31:0] rnd;
        logic [31:0] rnd2;
        logic [19:0] hi;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        st_off = 12'h000;
        emit(i_type(12'h400, ZERO, 3'b000, STORE_BASE, OPC_OP_IMM));
        emit(i_type(12'h200, ZERO, 3'b000, LOAD_BASE, OPC_OP_IMM));
        // x1 negative, x2 positive, the rest shifted into the upper word
        for (int r = 1; r <= 7; r++) begin
            rnd = $urandom();
            rnd2 = $urandom();
            hi = rnd[19:0];
            if (r == 1) hi[19] = 1'b1;
            if (r == 2) hi[19:18] = 2'b01;
            emit(u_type(hi, 5'(r), OPC_LUI));
            emit(i_type(rnd2[11:0], 5'(r), 3'b000, 5'(r), OPC_OP_IMM));
            if (r >= 3) begin
                emit(i_type({6'b0, rnd2[17:12]}, 5'(r), 3'b001, 5'(r), OPC_OP_IMM));
                emit(i_type(rnd2[29:18], 5'(r), 3'b000, 5'(r), OPC_OP_IMM));
            end
            store_reg(5'(r));
        end
        for (int n = 0; n < 40; n++) begin
            rnd = $urandom();
            rd = 5'(8 + $urandom_range(7, 0));
            rs1 = 5'(1 + $urandom_range(6, 0));
            rs2 = 5'(1 + $urandom_range(6, 0));
            f3 = rnd[2:0];
            alt = rnd[3] && ((f3 == 3'b000) || (f3 == 3'b101));
            case (rnd[5:4])
                2'd0: emit(r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd, OPC_OP));
                2'd1: begin
                    // Shift immediates carry only shamt and the arithmetic bit
                    if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, alt && f3[2], 4'b0, rnd[11:6]};
                    else imm = rnd[17:6];
                    emit(i_type(imm, rs1, f3, rd, OPC_OP_IMM));
                end
                2'd2: emit(r_type({1'b0, rnd[3], 5'b0}, rs2, rs1, 3'b000, rd, OPC_OP_W));
                default: emit(i_type(rnd[17:6], rs1, 3'b000, rd, OPC_OP_IMM_W));
            endcase
            store_reg(rd);
        end
        // slt and sltu on operands of opposite sign
        for (int k = 0; k < 4; k++) begin
            rs1 = k[0] ? X2 : X1;
            rs2 = k[0] ? X1 : X2;
            emit(r_type(7'b0, rs2, rs1, {2'b01, k[1]}, 5'd8, OPC_OP));
            store_reg(5'd8);
        end
        // Marker 2 on the taken path, 1 on fall-through
        for (int c = 0; c < 8; c++) begin
            if (c != 2 && c != 3) begin
                for (int p = 0; p < 3; p++) begin
                    rs1 = (p == 1) ? X2 : ((p == 0) ? X1 : X3);
                    rs2 = (p == 0) ? X2 : ((p == 1) ? X1 : X3);
                    emit(b_type(13'd12, rs2, rs1, 3'(c), OPC_BRANCH));
                    emit(i_type(12'd1, ZERO, 3'b000, MARK, OPC_OP_IMM));
                    emit(j_type(21'd8, ZERO, OPC_JAL));
                    emit(i_type(12'd2, ZERO, 3'b000, MARK, OPC_OP_IMM));
                    store_reg(MARK);
                end
            end
        end
        // JAL skips two writes of FLAG
        emit(i_type(12'h011, ZERO, 3'b000, FLAG, OPC_OP_IMM));
        emit(j_type(21'd12, LINK, OPC_JAL));
        emit(i_type(12'h066, ZERO, 3'b000, FLAG, OPC_OP_IMM));
        emit(i_type(12'h077, ZERO, 3'b000, FLAG, OPC_OP_IMM));
        store_reg(LINK);
        store_reg(FLAG);
        // JALR to an odd offset lands 16 bytes after the AUIPC
        emit(u_type(20'h0, PC_COPY, OPC_AUIPC));
        emit(i_type(12'd17, PC_COPY, 3'b000, LINK_R, OPC_JALR));
        emit(i_type(12'h066, ZERO, 3'b000, FLAG, OPC_OP_IMM));
        emit(i_type(12'h077, ZERO, 3'b000, FLAG, OPC_OP_IMM));
        store_reg(LINK_R);
        store_reg(FLAG);
        store_reg(PC_COPY);
        for (int w = 0; w < 7; w++) begin
            emit(i_type(12'd0, LOAD_BASE, 3'(w), LOADED, OPC_LOAD));
            store_reg(LOADED);
        end
        emit(32'h0000_0073);
    endtask

    function automatic void set_reg(input logic [4:0] rd, input logic [63:0] value);
        if (rd != 5'd0) ref_regs[rd] = value;
    endfunction

    function automatic logic [63:0] sext_word(input logic [63:0] v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    function automatic logic [63:0] arith(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[5:0];
            3'b010:  return {63'b0, $signed(a) < $signed(b)};
            3'b011:  return {63'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[5:0];
                else return a >> b[5:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction and returns the next PC (unchanged on halt)
    function automatic logic [63:0] ref_step(input logic [63:0] pc);
        logic [31:0] ins;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] addr;
        logic [63:0] word;
        logic [63:0] next_pc;
        logic        take;
        ins = imem[pc[10:2]];
        rd = ins[11:7];
        f3 = ins[14:12];
        a = ref_regs[ins[19:15]];
        b = ref_regs[ins[24:20]];
        imm_i = {{52{ins[31]}}, ins[31:20]};
        next_pc = pc + 64'd4;
        case (ins[6:0])
            OPC_LUI:   set_reg(rd, {{32{ins[31]}}, ins[31:12], 12'h000});
            OPC_AUIPC: set_reg(rd, pc + {{32{ins[31]}}, ins[31:12], 12'h000});
            OPC_JAL: begin
                set_reg(rd, pc + 64'd4);
                next_pc = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                next_pc = (a + imm_i) & ~64'd1;
                set_reg(rd, pc + 64'd4);
            end
            OPC_BRANCH: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) next_pc = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            OPC_LOAD: begin
                addr = a + imm_i;
                word = ref_mem[addr[11:3]];
                case (f3)
                    3'b000:  set_reg(rd, {{56{word[7]}}, word[7:0]});
                    3'b001:  set_reg(rd, {{48{word[15]}}, word[15:0]});
                    3'b010:  set_reg(rd, sext_word(word));
                    3'b011:  set_reg(rd, word);
                    3'b100:  set_reg(rd, {56'h0, word[7:0]});
                    3'b101:  set_reg(rd, {48'h0, word[15:0]});
                    3'b110:  set_reg(rd, {32'h0, word[31:0]});
                    default: next_pc = pc;
                endcase
            end
            OPC_STORE: begin
                if (f3 == 3'b011) begin
                    addr = a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_mem[addr[11:3]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end else begin
                    next_pc = pc;
                end
            end
            OPC_OP_IMM: set_reg(rd, arith(f3, ins[30] && (f3 == 3'b101), a, imm_i));
            OPC_OP:     set_reg(rd, arith(f3, ins[30], a, b));
            OPC_OP_IMM_W: begin
                if (f3 == 3'b000) set_reg(rd, sext_word(a + imm_i));
                else next_pc = pc;
            end
            OPC_OP_W: begin
                if (f3 == 3'b000) set_reg(rd, sext_word(ins[30] ? a - b : a + b));
                else next_pc = pc;
            end
            default: next_pc = pc;
        endcase
        return next_pc;
    endfunction

    task automatic run_reference();
        logic [63:0] pc;
        logic [63:0] next_pc;
        int          steps;
        pc = `RV_RESET_PC;
        steps = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 64'h0;
        end
        for (int i = 0; i < 512; i++) begin
            ref_mem[i] = dmem[i];
        end
        next_pc = ref_step(pc);
        while (next_pc != pc && steps < prog_len) begin
            pc = next_pc;
            next_pc = ref_step(pc);
            steps++;
        end
        halt_pc = pc;
        assert (next_pc == pc) else begin
            other_errors++;
            $display("Reference model ran past the end of the program without halting");
        end
    endtask

    task automatic report_counts();
        $display("Errors: data_address %0d, write_data %0d, instruction_address %0d, other %0d",
                 addr_errors, data_errors, pc_errors, other_errors);
    endtask

    // Values at the falling edge are the ones committed at the next rising edge
    always @(negedge clock) begin
        if (rst_n && mem_write) begin
            assert (store_count < exp_addr.size()) else begin
                other_errors++;
                $display("Unexpected store to address %h after all %0d expected stores",
                         data_address, exp_addr.size());
            end
            if (store_count < exp_addr.size()) begin
                assert (data_address == exp_addr[store_count]) else begin
                    addr_errors++;
                    $display("FAILED data_address at store %0d: expected %h, got %h",
                             store_count, exp_addr[store_count], data_address);
                end
                assert (write_data == exp_data[store_count]) else begin
                    data_errors++;
                    $display("FAILED write_data at store %0d: expected %h, got %h",
                             store_count, exp_data[store_count], write_data);
                end
            end
            store_count++;
        end
    end

    initial begin
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge clock);
        other_errors++;
        $display("Timeout: core did not reach ECALL within %0d cycles", budget_cycles);
        report_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        void'($urandom(22736));
        for (int i = 0; i < 512; i++) begin
            imem[i] = {25'(i), OPC_SYSTEM};
            dmem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
        end
        dmem[64] = LOAD_WORD;
        build_program();
        run_reference();
        budget_cycles = 16 + 20 * prog_len;
        repeat (16) @(posedge clock);
        #1 rst_n = 1'b1;
        // Halted once the fetched instruction is the ECALL
        @(negedge clock);
        while (instruction[6:0] != OPC_SYSTEM) @(negedge clock);
        // No store may follow the halt
        repeat (20) @(negedge clock);
        // The PC must still sit on the ECALL the reference stopped at
        assert (instruction_address == halt_pc) else begin
            pc_errors++;
            $display("FAILED instruction_address at halt: expected %h, got %h",
                     halt_pc, instruction_address);
        end
        assert (store_count == exp_addr.size()) else begin
            other_errors++;
            $display("Store count wrong: %0d stores seen, %0d expected",
                     store_count, exp_addr.size());
        end
        report_counts();
        if (addr_errors == 0 && data_errors == 0 && pc_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_pkg.sv
register_file.sv
alu.sv
imm_gen.sv
dataflow.sv
control_unit.sv
core_top.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f tb.f --top-module tb_core -o tb_core

./obj_dir/tb_core > sim.log 2>&1
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1
